// File: hdl/klClkPkg.sv
/* Shared types for the clock control block: APB port, clock functions,
   load data views, configuration and status groupings. */
`default_nettype none

package klClkPkg;

  localparam int APB_ADDR_W = 4;
  localparam int APB_DATA_W = 8;
  localparam int BURST_W    = 8;

  // Diagnostic address map
  localparam logic [APB_ADDR_W-1:0] CTL_LAST_ADDR  = 4'd6;
  localparam logic [APB_ADDR_W-1:0] DIAG_LAST_ADDR = 4'd5;
  localparam logic [APB_ADDR_W-1:0] BURST_LO_ADDR  = 4'd10;
  localparam logic [APB_ADDR_W-1:0] BURST_HI_ADDR  = 4'd11;
  localparam logic [APB_ADDR_W-1:0] DIS_ADDR       = 4'd13;
  localparam logic [APB_ADDR_W-1:0] CHK_ADDR       = 4'd14;

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
  } apbReqT;

  typedef struct packed {
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apbRspT;

  // Code 7 reserved
  typedef enum logic [2:0] {
    ctlStop       = 3'd0,
    ctlStart      = 3'd1,
    ctlSingleStep = 3'd2,
    ctlEboxSs     = 3'd3,
    ctlBurst      = 3'd4,
    ctlClrReset   = 3'd5,
    ctlSetReset   = 3'd6
  } ctlFuncE;

  typedef struct packed {
    logic    valid;
    ctlFuncE func;
  } ctlCmdT;

  typedef struct packed {
    logic spare;
    logic crmDis;
    logic edpDis;
    logic ctlDis;
  } disViewT;

  typedef struct packed {
    logic errStopEn;
    logic fmChk;
    logic cramChk;
    logic dramChk;
  } chkViewT;

  // Low nibble of a load write, read per target register
  typedef union packed {
    logic [3:0] burstNibble;
    disViewT    disView;
    chkViewT    chkView;
  } loadDataU;

  typedef struct packed {
    logic       loLoad;
    logic       hiLoad;
    logic [3:0] nibble;
  } burstLoadT;

  typedef struct packed {
    logic crm;
    logic edp;
    logic ctl;
  } sectionEnT;

  typedef struct packed {
    logic dram;
    logic cram;
    logic fm;
  } parChkT;

  typedef struct packed {
    sectionEnT dis;
    parChkT    chk;
    logic      errStopEn;
  } clkCfgT;

  typedef struct packed {
    logic go;
    logic burstMode;
    logic eboxSs;
  } runStateT;

  typedef logic [1:0] timeFieldT;
  typedef logic [5:0] diagWordT;

endpackage

`default_nettype wire

// File: hdl/diagApb.sv
/* APB diagnostic port: issues clock functions, loads burst nibbles and
   configuration, and returns the six diagnostic status words. */
`default_nettype none

module diagApb import klClkPkg::*; (
  input  logic                CLK,
  input  logic                arstN,
  input  apbReqT              apbReq,
  output apbRspT              apbRsp,
  output ctlCmdT              ctlCmd,
  output burstLoadT           burstLoad,
  output clkCfgT              cfg,
  input  logic [BURST_W-1:0]  burstCount,
  input  runStateT            runState,
  input  logic                mrReset,
  input  logic                errorStop,
  input  parChkT              parErr,
  input  diagWordT            pulseCount
);

  logic     access;
  logic     wrAcc;
  logic     rdAcc;
  logic     ctlHit;
  logic     loHit;
  logic     hiHit;
  logic     disHit;
  logic     chkHit;
  logic     rdHit;
  loadDataU loadData;
  diagWordT diagWord;

  // Every transfer completes in its first access cycle
  assign access = apbReq.psel & apbReq.penable;
  assign wrAcc  = access & apbReq.pwrite;
  assign rdAcc  = access & ~apbReq.pwrite;

  assign ctlHit = apbReq.paddr <= CTL_LAST_ADDR;
  assign loHit  = apbReq.paddr == BURST_LO_ADDR;
  assign hiHit  = apbReq.paddr == BURST_HI_ADDR;
  assign disHit = apbReq.paddr == DIS_ADDR;
  assign chkHit = apbReq.paddr == CHK_ADDR;
  assign rdHit  = apbReq.paddr <= DIAG_LAST_ADDR;

  assign loadData = apbReq.pwdata[3:0];

  // Burst nibbles go straight to the counter
  assign burstLoad.loLoad = wrAcc & loHit;
  assign burstLoad.hiLoad = wrAcc & hiHit;
  assign burstLoad.nibble = loadData.burstNibble;

  // Function pulse lands the cycle after the access
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      ctlCmd <= '0;
      cfg    <= '0;
    end else begin
      ctlCmd.valid <= wrAcc & ctlHit;
      ctlCmd.func  <= ctlFuncE'(apbReq.paddr[2:0]);
      if (wrAcc && disHit) begin
        cfg.dis.crm <= loadData.disView.crmDis;
        cfg.dis.edp <= loadData.disView.edpDis;
        cfg.dis.ctl <= loadData.disView.ctlDis;
      end
      if (wrAcc && chkHit) begin
        cfg.errStopEn <= loadData.chkView.errStopEn;
        cfg.chk.fm    <= loadData.chkView.fmChk;
        cfg.chk.cram  <= loadData.chkView.cramChk;
        cfg.chk.dram  <= loadData.chkView.dramChk;
      end
    end
  end

  always_comb begin
    diagWord = '0;
    case (apbReq.paddr[2:0])
      3'd0: diagWord = burstCount[7:2];
      3'd1: diagWord = {burstCount[1:0], runState.go, runState.burstMode,
                        runState.eboxSs, mrReset};
      3'd2: diagWord = {errorStop, 2'b00, cfg.dis.crm, cfg.dis.edp, cfg.dis.ctl};
      3'd3: diagWord = {2'b00, cfg.errStopEn, cfg.chk.fm, cfg.chk.cram, cfg.chk.dram};
      3'd4: diagWord = {3'b000, parErr};
      3'd5: diagWord = pulseCount;
      default: diagWord = '0;
    endcase
  end

  assign apbRsp.prdata  = (rdAcc && rdHit) ? APB_DATA_W'(diagWord) : '0;
  assign apbRsp.pready  = 1'b1;
  assign apbRsp.pslverr = apbReq.pwrite ?
                          wrAcc & ~(ctlHit | loHit | hiHit | disHit | chkHit) :
                          rdAcc & ~rdHit;

  // Master must hold a setup cycle before enable
  penableAfterPsel: assert property (@(posedge CLK) disable iff (!arstN)
    $rose(apbReq.penable) |-> apbReq.psel && $past(apbReq.psel));

endmodule

`default_nettype wire

// File: hdl/burstCounter.sv
/* Burst length counter, loaded one nibble at a time over the diagnostic
   port and decremented on every gated burst cycle. */
`default_nettype none

module burstCounter import klClkPkg::*; (
  input  logic               CLK,
  input  logic               arstN,
  input  burstLoadT          burstLoad,
  input  logic               gatedEn,
  input  logic               burstMode,
  output logic [BURST_W-1:0] burstCount,
  output logic               burstNonZero
);

  logic decrement;

  assign decrement = gatedEn & burstMode;

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      burstCount <= '0;
    end else begin
      if (burstLoad.loLoad) begin
        burstCount[3:0] <= burstLoad.nibble;
      end
      if (burstLoad.hiLoad) begin
        burstCount[7:4] <= burstLoad.nibble;
      end
      if (decrement && !burstLoad.loLoad && !burstLoad.hiLoad) begin
        burstCount <= burstCount - 1'b1;
      end
    end
  end

  // Count left after this cycle's decrement, so the registered gate
  // drops right after the last burst cycle
  assign burstNonZero = decrement ? (burstCount > BURST_W'(1)) : (burstCount != '0);

  // Gate control must stop bursting before the count runs out
  noDecFromZero: assert property (@(posedge CLK) disable iff (!arstN)
    decrement |-> burstCount != '0);

endmodule

`default_nettype wire

// File: hdl/clkGate.sv
/* Clock run modes, registered gated enable, error stop and the machine
   reset flag, driven by clock functions from the diagnostic port. */
`default_nettype none

module clkGate import klClkPkg::*; (
  input  logic     CLK,
  input  logic     arstN,
  input  ctlCmdT   ctlCmd,
  input  clkCfgT   cfg,
  input  logic     burstNonZero,
  input  logic     eboxClkEn,
  input  logic     anyErr,
  output logic     gatedEn,
  output runStateT runState,
  output logic     errorStop,
  output logic     mrReset
);

  logic stepReq;
  logic gateQ;
  logic gateNext;
  logic modeCmd;

  assign errorStop = cfg.errStopEn & anyErr;
  // Error stop blocks the gate in the same cycle it rises
  assign gatedEn   = gateQ & ~errorStop;

  assign modeCmd = ctlCmd.valid && ctlCmd.func inside {ctlStop, ctlStart,
                   ctlSingleStep, ctlEboxSs, ctlBurst};

  always_comb begin
    gateNext = runState.go |
               (runState.burstMode & burstNonZero) |
               (stepReq & ~gatedEn) |
               (runState.eboxSs & ~eboxClkEn);
    gateNext = gateNext & ~errorStop;
  end

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      runState <= '0;
      stepReq  <= 1'b0;
      gateQ    <= 1'b0;
    end else begin
      gateQ <= gateNext;
      if (modeCmd) begin
        // New mode replaces the old one, stop leaves none
        runState <= '0;
        stepReq  <= 1'b0;
        case (ctlCmd.func)
          ctlStart:      runState.go        <= 1'b1;
          ctlSingleStep: stepReq            <= 1'b1;
          ctlEboxSs:     runState.eboxSs    <= 1'b1;
          ctlBurst:      runState.burstMode <= 1'b1;
          default:       ;
        endcase
      end else begin
        if (gatedEn) stepReq <= 1'b0;
        if (eboxClkEn) runState.eboxSs <= 1'b0;
        if (runState.burstMode && !burstNonZero) runState.burstMode <= 1'b0;
      end
    end
  end

  // Machine reset comes up set
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      mrReset <= 1'b1;
    end else if (ctlCmd.valid && ctlCmd.func == ctlSetReset) begin
      mrReset <= 1'b1;
    end else if (ctlCmd.valid && ctlCmd.func == ctlClrReset) begin
      mrReset <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/eboxSync.sv
/* EBOX clock sync: phase counter matched against the microcode time field,
   per-section enables and a running count of EBOX clock pulses. */
`default_nettype none

module eboxSync import klClkPkg::*; #(
  parameter int PULSE_CNT_W = 6
) (
  input  logic                   CLK,
  input  logic                   arstN,
  input  logic                   gatedEn,
  input  timeFieldT              timeField,
  input  clkCfgT                 cfg,
  output logic                   eboxClkEn,
  output sectionEnT              sectionEn,
  output logic [PULSE_CNT_W-1:0] pulseCount
);

  timeFieldT phase;

  // Fires on the gated cycle where the phase reaches the time field
  assign eboxClkEn = gatedEn & (phase == timeField);

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      phase <= '0;
    end else if (gatedEn) begin
      phase <= eboxClkEn ? '0 : phase + 1'b1;
    end
  end

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      pulseCount <= '0;
    end else if (eboxClkEn) begin
      pulseCount <= pulseCount + 1'b1;
    end
  end

  // Section clocks follow the EBOX clock unless disabled
  assign sectionEn.crm = eboxClkEn & ~cfg.dis.crm;
  assign sectionEn.edp = eboxClkEn & ~cfg.dis.edp;
  assign sectionEn.ctl = eboxClkEn & ~cfg.dis.ctl;

endmodule

`default_nettype wire

// File: hdl/parityErr.sv
/* Parity error capture: samples DRAM, CRAM and FM parity status on EBOX
   clocks and holds enabled failures until a clear reset function. */
`default_nettype none

module parityErr import klClkPkg::*; (
  input  logic   CLK,
  input  logic   arstN,
  input  ctlCmdT ctlCmd,
  input  clkCfgT cfg,
  input  logic   eboxClkEn,
  input  parChkT parityOk,
  output parChkT parErr,
  output logic   anyErr
);

  logic   clrErr;
  parChkT newErr;

  assign clrErr = ctlCmd.valid && ctlCmd.func == ctlClrReset;

  // Checked source with bad parity on this EBOX clock
  assign newErr.dram = eboxClkEn & cfg.chk.dram & ~parityOk.dram;
  assign newErr.cram = eboxClkEn & cfg.chk.cram & ~parityOk.cram;
  assign newErr.fm   = eboxClkEn & cfg.chk.fm & ~parityOk.fm;

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      parErr <= '0;
    end else if (clrErr) begin
      parErr <= '0;
    end else begin
      parErr <= parErr | newErr;
    end
  end

  assign anyErr = |parErr;

endmodule

`default_nettype wire

// File: hdl/klClkTop.sv
/* Clock control top level. Connects the APB diagnostic port to the burst
   counter, gate control, EBOX sync and parity error blocks. */
`default_nettype none

module klClkTop import klClkPkg::*; (
  input  logic      CLK,
  input  logic      arstN,
  input  apbReqT    apbReq,
  output apbRspT    apbRsp,
  input  timeFieldT timeField,
  input  parChkT    parityOk,
  output logic      gatedEn,
  output logic      eboxClkEn,
  output logic      errorStop,
  output logic      mrReset,
  output sectionEnT sectionEn
);

  // Matches the diagnostic word width
  localparam int PULSE_CNT_W = 6;

  ctlCmdT                 ctlCmd;
  burstLoadT              burstLoad;
  clkCfgT                 cfg;
  logic [BURST_W-1:0]     burstCount;
  logic                   burstNonZero;
  runStateT               runState;
  parChkT                 parErr;
  logic                   anyErr;
  logic [PULSE_CNT_W-1:0] pulseCount;

  diagApb uDiagApb (
    .CLK        (CLK),
    .arstN      (arstN),
    .apbReq     (apbReq),
    .apbRsp     (apbRsp),
    .ctlCmd     (ctlCmd),
    .burstLoad  (burstLoad),
    .cfg        (cfg),
    .burstCount (burstCount),
    .runState   (runState),
    .mrReset    (mrReset),
    .errorStop  (errorStop),
    .parErr     (parErr),
    .pulseCount (pulseCount)
  );

  burstCounter uBurstCounter (
    .CLK          (CLK),
    .arstN        (arstN),
    .burstLoad    (burstLoad),
    .gatedEn      (gatedEn),
    .burstMode    (runState.burstMode),
    .burstCount   (burstCount),
    .burstNonZero (burstNonZero)
  );

  clkGate uClkGate (
    .CLK          (CLK),
    .arstN        (arstN),
    .ctlCmd       (ctlCmd),
    .cfg          (cfg),
    .burstNonZero (burstNonZero),
    .eboxClkEn    (eboxClkEn),
    .anyErr       (anyErr),
    .gatedEn      (gatedEn),
    .runState     (runState),
    .errorStop    (errorStop),
    .mrReset      (mrReset)
  );

  eboxSync #(
    .PULSE_CNT_W (PULSE_CNT_W)
  ) uEboxSync (
    .CLK        (CLK),
    .arstN      (arstN),
    .gatedEn    (gatedEn),
    .timeField  (timeField),
    .cfg        (cfg),
    .eboxClkEn  (eboxClkEn),
    .sectionEn  (sectionEn),
    .pulseCount (pulseCount)
  );

  parityErr uParityErr (
    .CLK       (CLK),
    .arstN     (arstN),
    .ctlCmd    (ctlCmd),
    .cfg       (cfg),
    .eboxClkEn (eboxClkEn),
    .parityOk  (parityOk),
    .parErr    (parErr),
    .anyErr    (anyErr)
  );

endmodule

`default_nettype wire

// File: tb/klClkChecker.sv
/* Cycle model of the clock control block for the testbench. Watches the
   APB port and all outputs, and compares each cycle against the model. */
`default_nettype none

module klClkChecker import klClkPkg::*; (
  input  logic      CLK,
  input  logic      arstN,
  input  apbReqT    apbReq,
  input  apbRspT    apbRsp,
  input  timeFieldT timeField,
  input  parChkT    parityOk,
  input  logic      gatedEn,
  input  logic      eboxClkEn,
  input  logic      errorStop,
  input  logic      mrReset,
  input  sectionEnT sectionEn,
  output int        errCount,
  output int        checkCount
);

  // Mirrored configuration, disables as {crm, edp, ctl}, checks as {dram, cram, fm}
  logic [2:0] disM;
  logic [2:0] chkM;
  logic       stopEnM;
  logic [2:0] errM;
  logic       mrM;
  // Clock function written in the previous access cycle
  logic       cmdPend;
  logic [2:0] cmdFunc;
  logic       goM;
  logic       burstM;
  logic       eboxSsM;
  logic       stepM;
  logic       gateM;
  int         burstLeft;
  logic [1:0] phaseM;
  logic [5:0] pulseM;

  // Per-cycle scratch values
  logic stopNow;
  logic gateNow;
  logic eboxNow;
  logic wantGate;
  logic access;
  logic wrAcc;
  logic validAddr;
  int   left;
  int   oldBurst;

  task automatic checkValue(input string what, input logic [7:0] got, input logic [7:0] exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("[ERROR] t=%0t %s: got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  function automatic logic [7:0] expectedWord(input logic [3:0] addr);
    logic [7:0] burst;
    burst = burstLeft;
    case (addr)
      4'd0: return {2'b00, burst[7:2]};
      4'd1: return {2'b00, burst[1:0], goM, burstM, eboxSsM, mrM};
      4'd2: return {2'b00, stopNow, 2'b00, disM};
      4'd3: return {4'h0, stopEnM, chkM[0], chkM[1], chkM[2]};
      4'd4: return {5'b00000, errM};
      4'd5: return {2'b00, pulseM};
      default: return 8'h00;
    endcase
  endfunction

  initial begin
    errCount   = 0;
    checkCount = 0;
  end

  // Outputs are stable mid-cycle; the model then steps to the next edge
  always @(negedge CLK) begin
    if (!arstN) begin
      disM      = '0;
      chkM      = '0;
      stopEnM   = 1'b0;
      errM      = '0;
      mrM       = 1'b1;
      cmdPend   = 1'b0;
      cmdFunc   = '0;
      goM       = 1'b0;
      burstM    = 1'b0;
      eboxSsM   = 1'b0;
      stepM     = 1'b0;
      gateM     = 1'b0;
      burstLeft = 0;
      phaseM    = '0;
      pulseM    = '0;
    end else begin
      stopNow = stopEnM & (|errM);
      gateNow = gateM & ~stopNow;
      eboxNow = gateNow & (phaseM == timeField);
      checkValue("gatedEn", gatedEn, gateNow);
      checkValue("eboxClkEn", eboxClkEn, eboxNow);
      checkValue("sectionEn", sectionEn, {3{eboxNow}} & ~disM);
      checkValue("errorStop", errorStop, stopNow);
      checkValue("mrReset", mrReset, mrM);

      access = apbReq.psel & apbReq.penable;
      wrAcc  = access & apbReq.pwrite;
      if (access) begin
        checkValue("pready", apbRsp.pready, 1'b1);
        if (apbReq.pwrite) begin
          validAddr = apbReq.paddr <= 4'd6 || apbReq.paddr == 4'd10 ||
                      apbReq.paddr == 4'd11 || apbReq.paddr == 4'd13 ||
                      apbReq.paddr == 4'd14;
          checkValue($sformatf("pslverr on write to %0d", apbReq.paddr),
                     apbRsp.pslverr, !validAddr);
        end else begin
          validAddr = apbReq.paddr <= 4'd5;
          checkValue($sformatf("pslverr on read of %0d", apbReq.paddr),
                     apbRsp.pslverr, !validAddr);
          checkValue($sformatf("diagnostic word %0d", apbReq.paddr), apbRsp.prdata,
                     validAddr ? expectedWord(apbReq.paddr) : 8'h00);
        end
      end

      // Gate wanted for the next cycle, from the modes as they stand now
      oldBurst = burstLeft;
      left     = burstLeft - (gateNow & burstM);
      wantGate = goM | (burstM && left > 0) | (stepM & ~gateNow) | (eboxSsM & ~eboxNow);
      gateM    = wantGate & ~stopNow;
      if (gateNow) begin
        phaseM = eboxNow ? 2'd0 : phaseM + 2'd1;
      end
      if (eboxNow) begin
        pulseM = pulseM + 6'd1;
      end

      if (cmdPend && cmdFunc == 3'd5) begin
        errM = '0;
        mrM  = 1'b0;
      end else if (eboxNow) begin
        errM = errM | (chkM & ~parityOk);
      end
      if (cmdPend && cmdFunc == 3'd6) begin
        mrM = 1'b1;
      end
      if (cmdPend && cmdFunc <= 3'd4) begin
        goM     = cmdFunc == 3'd1;
        stepM   = cmdFunc == 3'd2;
        eboxSsM = cmdFunc == 3'd3;
        burstM  = cmdFunc == 3'd4;
      end else begin
        if (gateNow) stepM = 1'b0;
        if (eboxNow) eboxSsM = 1'b0;
        if (left == 0) burstM = 1'b0;
      end
      burstLeft = left;

      // Effects of this cycle's write
      cmdPend = wrAcc && apbReq.paddr <= 4'd6;
      cmdFunc = apbReq.paddr[2:0];
      if (wrAcc && apbReq.paddr == 4'd10) begin
        burstLeft = (oldBurst & 240) | apbReq.pwdata[3:0];
      end
      if (wrAcc && apbReq.paddr == 4'd11) begin
        burstLeft = (oldBurst & 15) | (apbReq.pwdata[3:0] << 4);
      end
      if (wrAcc && apbReq.paddr == 4'd13) begin
        disM = apbReq.pwdata[2:0];
      end
      if (wrAcc && apbReq.paddr == 4'd14) begin
        stopEnM = apbReq.pwdata[3];
        chkM    = {apbReq.pwdata[0], apbReq.pwdata[1], apbReq.pwdata[2]};
      end
    end
  end

endmodule

`default_nettype wire

// File: tb/klClkTb.sv
/* Testbench for the clock control block. Drives random APB traffic,
   time fields and parity inputs, and reports per-test results. */
`default_nettype none

module klClkTb import klClkPkg::*; ();

  // Longest test stays far below this, five tests in all
  localparam int MaxTestCycles = 4000;
  localparam int TimeoutCycles = 5 * MaxTestCycles;

  logic      CLK;
  logic      arstN;
  apbReqT    apbReq;
  apbRspT    apbRsp;
  timeFieldT timeField;
  parChkT    parityOk;
  logic      gatedEn;
  logic      eboxClkEn;
  logic      errorStop;
  logic      mrReset;
  sectionEnT sectionEn;
  int        errCount;
  int        checkCount;
  integer    seed;
  int        cycleCount = 0;
  int        testsRun;
  int        testsPassed;
  int        errAtStart;

  klClkTop u_dut (
    .CLK       (CLK),
    .arstN     (arstN),
    .apbReq    (apbReq),
    .apbRsp    (apbRsp),
    .timeField (timeField),
    .parityOk  (parityOk),
    .gatedEn   (gatedEn),
    .eboxClkEn (eboxClkEn),
    .errorStop (errorStop),
    .mrReset   (mrReset),
    .sectionEn (sectionEn)
  );

  klClkChecker uChecker (
    .CLK        (CLK),
    .arstN      (arstN),
    .apbReq     (apbReq),
    .apbRsp     (apbRsp),
    .timeField  (timeField),
    .parityOk   (parityOk),
    .gatedEn    (gatedEn),
    .eboxClkEn  (eboxClkEn),
    .errorStop  (errorStop),
    .mrReset    (mrReset),
    .sectionEn  (sectionEn),
    .errCount   (errCount),
    .checkCount (checkCount)
  );

  initial CLK = 1'b0;
  always #2 CLK = ~CLK;

  always @(posedge CLK) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic int randRange(input int lo, input int hi);
    return lo + ($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  // One transfer, setup then access until pready; returns 1 unit after an edge
  task automatic apbXfer(input logic isWrite, input logic [3:0] addr,
                         input logic [7:0] data);
    apbReq.psel    = 1'b1;
    apbReq.penable = 1'b0;
    apbReq.pwrite  = isWrite;
    apbReq.paddr   = addr;
    apbReq.pwdata  = data;
    @(posedge CLK);
    #1;
    apbReq.penable = 1'b1;
    do @(negedge CLK); while (!apbRsp.pready);
    @(posedge CLK);
    #1;
    apbReq.psel    = 1'b0;
    apbReq.penable = 1'b0;
  endtask

  task automatic apbWrite(input logic [3:0] addr, input logic [7:0] data);
    apbXfer(1'b1, addr, data);
  endtask

  task automatic apbRead(input logic [3:0] addr);
    apbXfer(1'b0, addr, 8'h00);
  endtask

  // Waits for a gated stretch to start and end
  task automatic waitGatedRun();
    do @(negedge CLK); while (!gatedEn);
    do @(negedge CLK); while (gatedEn);
    @(posedge CLK);
    #1;
  endtask

  task automatic waitGateLow();
    do @(negedge CLK); while (gatedEn);
    @(posedge CLK);
    #1;
  endtask

  task automatic waitEboxPulses(input int count);
    repeat (count) begin
      do @(negedge CLK); while (!eboxClkEn);
    end
    @(posedge CLK);
    #1;
  endtask

  task automatic waitErrorStop();
    do @(negedge CLK); while (!errorStop);
    @(posedge CLK);
    #1;
  endtask

  task automatic finishTest(input string name);
    testsRun++;
    if (errCount == errAtStart) begin
      testsPassed++;
      $display("Test %0d %s: pass", testsRun, name);
    end else begin
      $display("Test %0d %s: fail with %0d errors", testsRun, name, errCount - errAtStart);
    end
    errAtStart = errCount;
  endtask

  task automatic regReadbackTest();
    int addr;
    apbRead(4'd1);
    repeat (3) begin
      apbWrite(DIS_ADDR, randRange(0, 15));
      apbWrite(CHK_ADDR, randRange(0, 15));
      apbRead(4'd2);
      apbRead(4'd3);
    end
    // Unmapped space, and 6 is a valid write but not a valid read
    for (addr = 6; addr < 16; addr++) begin
      if (addr != 10 && addr != 11 && addr != 13 && addr != 14) begin
        apbRead(addr);
        if (addr != 6) apbWrite(addr, randRange(0, 255));
      end
    end
    finishTest("register readback and bad addresses");
  endtask

  task automatic burstLengthTest();
    int count;
    repeat (3) begin
      count = randRange(1, 63);
      apbWrite(BURST_LO_ADDR, count % 16);
      apbWrite(BURST_HI_ADDR, count / 16);
      apbWrite(ctlBurst, 8'h00);
      waitGatedRun();
      apbRead(4'd0);
      apbRead(4'd1);
    end
    finishTest("burst length");
  endtask

  task automatic runModeTest();
    repeat (3) begin
      timeField = randRange(0, 3);
      apbWrite(DIS_ADDR, randRange(0, 15));
      apbWrite(ctlStart, 8'h00);
      waitEboxPulses(randRange(4, 20));
      apbWrite(ctlStop, 8'h00);
      waitGateLow();
      apbRead(4'd5);
    end
    finishTest("run mode and section enables");
  endtask

  task automatic stepModesTest();
    repeat (4) begin
      timeField = randRange(0, 3);
      apbWrite(ctlSingleStep, 8'h00);
      waitGatedRun();
      apbWrite(ctlEboxSs, 8'h00);
      waitGatedRun();
      apbRead(4'd1);
    end
    finishTest("single step and EBOX single step");
  endtask

  task automatic parityStopTest();
    int     badBit;
    parChkT chk;
    badBit = randRange(0, 2);
    chk = randRange(0, 7);
    chk[badBit] = 1'b1;
    timeField = randRange(0, 3);
    apbWrite(CHK_ADDR, {4'h0, 1'b1, chk.fm, chk.cram, chk.dram});
    parityOk = '1;
    parityOk[badBit] = 1'b0;
    apbWrite(ctlStart, 8'h00);
    waitErrorStop();
    // Gate must stay off while the error is held
    repeat (6) @(posedge CLK);
    #1;
    apbRead(4'd4);
    apbRead(4'd2);
    parityOk = '1;
    apbWrite(ctlClrReset, 8'h00);
    apbRead(4'd4);
    apbRead(4'd1);
    apbWrite(ctlSetReset, 8'h00);
    apbRead(4'd1);
    apbWrite(ctlStop, 8'h00);
    waitGateLow();
    apbWrite(CHK_ADDR, 8'h00);
    finishTest("parity error stop and reset flag");
  endtask

  initial begin
    seed        = 32'hb99c;
    arstN       = 1'b0;
    apbReq      = '0;
    timeField   = '0;
    parityOk    = '1;
    testsRun    = 0;
    testsPassed = 0;
    errAtStart  = 0;
    repeat (5) @(posedge CLK);
    #1;
    arstN = 1'b1;
    regReadbackTest();
    burstLengthTest();
    runModeTest();
    stepModesTest();
    parityStopTest();
    $display("Summary: %0d of %0d tests passed, %0d checks, %0d errors",
             testsPassed, testsRun, checkCount, errCount);
    if (errCount == 0 && testsPassed == testsRun && checkCount > 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: klClkTop.f
hdl/klClkPkg.sv
hdl/diagApb.sv
hdl/burstCounter.sv
hdl/clkGate.sv
hdl/eboxSync.sv
hdl/parityErr.sv
hdl/klClkTop.sv
tb/klClkChecker.sv
tb/klClkTb.sv

// File: Bender.yml
package:
  name: kl_clk

sources:
  - hdl/klClkPkg.sv
  - hdl/diagApb.sv
  - hdl/burstCounter.sv
  - hdl/clkGate.sv
  - hdl/eboxSync.sv
  - hdl/parityErr.sv
  - hdl/klClkTop.sv
  - target: test
    files:
      - tb/klClkChecker.sv
      - tb/klClkTb.sv
